// File: Makefile
# Verilator build and run of the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_sonata_periph
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: compile.f
rtl/sonata_periph_pkg.sv
rtl/periph_bus_if.sv
rtl/periph_decode.sv
rtl/gpio.sv
rtl/pwm.sv
rtl/timer.sv
rtl/sonata_periph_top.sv
test/tb_sonata_periph.sv

// File: rtl/gpio.sv
/* GPIO block with a byte-writable output register and a synchronized input register */
`timescale 1ns/10ps

module gpio (
  input  logic                                   clk_sys_i,
  input  logic                                   rst_n_i,
  periph_bus_if.device                           bus,
  input  logic [sonata_periph_pkg::GpiWidth-1:0] gp_i,
  output logic [sonata_periph_pkg::GpoWidth-1:0] gp_o
);
  import sonata_periph_pkg::*;

  logic [GpoWidth-1:0] gpo_q;
  logic [GpiWidth-1:0] gpi_meta_q;
  logic [GpiWidth-1:0] gpi_sync_q;
  bus_data_t           wmask;
  bus_data_t           rdata_d;
  logic                out_sel;
  logic                in_sel;
  logic                rvalid_q;
  logic                err_q;
  bus_data_t           rdata_q;

  assign out_sel = bus.addr == GpioOutOffset;
  assign in_sel  = bus.addr == GpioInOffset;

  // Byte enables to bit mask
  always_comb begin
    for (int b = 0; b < BusByteEnable; b++) begin
      wmask[b*8 +: 8] = {8{bus.be[b]}};
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      gpo_q      <= '0;
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
    end else begin
      gpi_meta_q <= gp_i;       // First stage, may go metastable
      gpi_sync_q <= gpi_meta_q;
      if (bus.req && bus.we && out_sel) begin
        gpo_q <= (gpo_q & ~wmask[GpoWidth-1:0]) |
                 (bus.wdata[GpoWidth-1:0] & wmask[GpoWidth-1:0]);
      end
    end
  end

  always_comb begin
    rdata_d = '0;
    if (out_sel) begin
      rdata_d[GpoWidth-1:0] = gpo_q;
    end else if (in_sel) begin
      rdata_d[GpiWidth-1:0] = gpi_sync_q;
    end
  end

  // Response one cycle after req
  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    err_q   <= !(out_sel || in_sel);
    rdata_q <= bus.we ? '0 : rdata_d; // Writes return zero
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = err_q;
  assign gp_o       = gpo_q;

endmodule

// File: rtl/periph_bus_if.sv
/* One decoded register access and its response, between the decoder and a device */
`timescale 1ns/10ps

interface periph_bus_if;
  import sonata_periph_pkg::*;

  // Request, valid for one cycle
  logic      req;
  logic      we;
  reg_addr_t addr;   // Offset inside the device
  bus_be_t   be;
  bus_data_t wdata;

  // Response, one cycle after req
  logic      rvalid;
  bus_data_t rdata;
  logic      err;

  modport host (
    output req, we, addr, be, wdata,
    input  rvalid, rdata, err
  );

  modport device (
    input  req, we, addr, be, wdata,
    output rvalid, rdata, err
  );

endinterface

// File: rtl/periph_decode.sv
/* Routes top-level register accesses to the device selected by the address and
   merges the device responses; unmapped selects are answered here with an error */
`timescale 1ns/10ps

module periph_decode (
  input  logic                         clk_sys_i,
  input  logic                         rst_n_i,
  input  logic                         bus_req_i,
  input  logic                         bus_we_i,
  input  sonata_periph_pkg::bus_addr_t bus_addr_i,
  input  sonata_periph_pkg::bus_be_t   bus_be_i,
  input  sonata_periph_pkg::bus_data_t bus_wdata_i,
  output logic                         bus_rvalid_o,
  output sonata_periph_pkg::bus_data_t bus_rdata_o,
  output logic                         bus_err_o,
  periph_bus_if.host                   gpio_bus,
  periph_bus_if.host                   pwm_bus,
  periph_bus_if.host                   timer_bus
);
  import sonata_periph_pkg::*;

  dev_sel_e  dev_sel;
  reg_addr_t reg_addr;
  logic      unmapped;
  logic      unmapped_q;

  assign dev_sel  = dev_sel_e'(bus_addr_i[DevSelLsb +: DevSelWidth]);
  assign reg_addr = bus_addr_i[RegAddrWidth-1:0];
  assign unmapped = bus_req_i && !(dev_sel inside {DevGpio, DevPwm, DevTimer});

  //////////////////////////////////////////////////////////////////////
  // Request path
  //////////////////////////////////////////////////////////////////////

  assign gpio_bus.req  = bus_req_i && (dev_sel == DevGpio);
  assign pwm_bus.req   = bus_req_i && (dev_sel == DevPwm);
  assign timer_bus.req = bus_req_i && (dev_sel == DevTimer);

  // Payload goes to all devices, only req is steered
  assign gpio_bus.we     = bus_we_i;
  assign gpio_bus.addr   = reg_addr;
  assign gpio_bus.be     = bus_be_i;
  assign gpio_bus.wdata  = bus_wdata_i;
  assign pwm_bus.we      = bus_we_i;
  assign pwm_bus.addr    = reg_addr;
  assign pwm_bus.be      = bus_be_i;
  assign pwm_bus.wdata   = bus_wdata_i;
  assign timer_bus.we    = bus_we_i;
  assign timer_bus.addr  = reg_addr;
  assign timer_bus.be    = bus_be_i;
  assign timer_bus.wdata = bus_wdata_i;

  //////////////////////////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      unmapped_q <= 1'b0;
    end else begin
      unmapped_q <= unmapped; // Local error response next cycle
    end
  end

  assign bus_rvalid_o = gpio_bus.rvalid | pwm_bus.rvalid | timer_bus.rvalid | unmapped_q;

  assign bus_rdata_o = ({BusDataWidth{gpio_bus.rvalid}}  & gpio_bus.rdata) |
                       ({BusDataWidth{pwm_bus.rvalid}}   & pwm_bus.rdata)  |
                       ({BusDataWidth{timer_bus.rvalid}} & timer_bus.rdata);

  assign bus_err_o = (gpio_bus.rvalid  & gpio_bus.err)  |
                     (pwm_bus.rvalid   & pwm_bus.err)   |
                     (timer_bus.rvalid & timer_bus.err) |
                     unmapped_q;

  // One responder per cycle across all devices
  OneRsp_A: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    $onehot0({gpio_bus.rvalid, pwm_bus.rvalid, timer_bus.rvalid, unmapped_q}));

endmodule

// File: rtl/pwm.sv
/* Bank of PWM channels; each has a duty and a period register and drives one pin
   high while its counter is below the duty value */
`timescale 1ns/10ps

module pwm (
  input  logic                                 clk_sys_i,
  input  logic                                 rst_n_i,
  periph_bus_if.device                         bus,
  output logic [sonata_periph_pkg::PwmNum-1:0] pwm_o
);
  import sonata_periph_pkg::*;

  typedef logic [PwmCtrSize-1:0] ctr_t;

  ctr_t                                 duty_q   [PwmNum];
  ctr_t                                 period_q [PwmNum];
  ctr_t                                 ctr_q    [PwmNum];
  logic [RegAddrWidth-PwmChanShift-1:0] chan_sel;
  logic [PwmChanShift-1:0]              chan_off;
  logic                                 duty_sel;
  logic                                 period_sel;
  logic                                 hit;
  logic                                 wr_en;
  bus_data_t                            rdata_d;
  logic                                 rvalid_q;
  logic                                 err_q;
  bus_data_t                            rdata_q;

  assign chan_sel   = bus.addr[RegAddrWidth-1:PwmChanShift];
  assign chan_off   = bus.addr[PwmChanShift-1:0];
  assign duty_sel   = chan_off == PwmDutyOffset[PwmChanShift-1:0];
  assign period_sel = chan_off == PwmPeriodOffset[PwmChanShift-1:0];
  assign hit        = (int'(chan_sel) < PwmNum) && (duty_sel || period_sel);
  assign wr_en      = bus.req && bus.we && hit;

  //////////////////////////////////////////////////////////////////////
  // Channel registers and counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < PwmNum; i++) begin
        duty_q[i]   <= '0;
        period_q[i] <= '0;
        ctr_q[i]    <= '0;
      end
    end else begin
      for (int i = 0; i < PwmNum; i++) begin
        // Also wraps when the period is lowered below the count
        ctr_q[i] <= (ctr_q[i] >= period_q[i]) ? '0 : ctr_q[i] + 1'b1;
        if (wr_en && int'(chan_sel) == i) begin
          if (duty_sel) begin
            duty_q[i] <= bus.wdata[PwmCtrSize-1:0];
          end
          if (period_sel) begin
            period_q[i] <= bus.wdata[PwmCtrSize-1:0];
          end
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < PwmNum; i++) begin
      pwm_o[i] = ctr_q[i] < duty_q[i];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Register read and response
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata_d = '0;
    for (int i = 0; i < PwmNum; i++) begin
      if (int'(chan_sel) == i) begin
        if (duty_sel) begin
          rdata_d[PwmCtrSize-1:0] = duty_q[i];
        end else if (period_sel) begin
          rdata_d[PwmCtrSize-1:0] = period_q[i];
        end
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    err_q   <= !hit;
    rdata_q <= (bus.we || !hit) ? '0 : rdata_d;
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = err_q;

endmodule

// File: rtl/sonata_periph_pkg.sv
/* Widths, address map and register offsets shared by the peripheral blocks.
   Imported by every RTL block and by the testbench */
package sonata_periph_pkg;

  // Bus field widths
  localparam int unsigned BusAddrWidth  = 32;
  localparam int unsigned BusDataWidth  = 32;
  localparam int unsigned BusByteEnable = 4;
  localparam int unsigned RegAddrWidth  = 8;

  typedef logic [BusAddrWidth-1:0]  bus_addr_t;
  typedef logic [BusDataWidth-1:0]  bus_data_t;
  typedef logic [BusByteEnable-1:0] bus_be_t;
  typedef logic [RegAddrWidth-1:0]  reg_addr_t;

  // Device select field, addr[15:12]
  localparam int unsigned DevSelLsb   = 12;
  localparam int unsigned DevSelWidth = 4;

  typedef enum logic [DevSelWidth-1:0] {
    DevGpio  = 4'd0,
    DevPwm   = 4'd1,
    DevTimer = 4'd2
  } dev_sel_e;

  // GPIO
  localparam int unsigned GpiWidth      = 13;
  localparam int unsigned GpoWidth      = 24;
  localparam reg_addr_t   GpioOutOffset = 8'h00;
  localparam reg_addr_t   GpioInOffset  = 8'h04;

  // PWM
  localparam int unsigned PwmNum          = 4;
  localparam int unsigned PwmCtrSize      = 8;
  localparam int unsigned PwmChanStride   = 8;
  localparam int unsigned PwmChanShift    = $clog2(PwmChanStride); // Channel index position
  localparam reg_addr_t   PwmDutyOffset   = 8'h00;
  localparam reg_addr_t   PwmPeriodOffset = 8'h04;

  // Machine timer
  localparam reg_addr_t TimerMtimeLo = 8'h00;
  localparam reg_addr_t TimerMtimeHi = 8'h04;
  localparam reg_addr_t TimerCmpLo   = 8'h08;
  localparam reg_addr_t TimerCmpHi   = 8'h0C;

endpackage

// File: rtl/sonata_periph_top.sv
/* Peripheral subsystem top; connects the address decoder to the GPIO, PWM and timer
   blocks. The host drives the register bus strobes on plain ports */
`timescale 1ns/10ps

module sonata_periph_top (
  input  logic                                   clk_sys_i,
  input  logic                                   rst_n_i,

  input  logic                                   bus_req_i,
  input  logic                                   bus_we_i,
  input  sonata_periph_pkg::bus_addr_t           bus_addr_i,
  input  sonata_periph_pkg::bus_be_t             bus_be_i,
  input  sonata_periph_pkg::bus_data_t           bus_wdata_i,
  output logic                                   bus_rvalid_o,
  output logic                                   bus_err_o,
  output sonata_periph_pkg::bus_data_t           bus_rdata_o,

  input  logic [sonata_periph_pkg::GpiWidth-1:0] gp_i,
  output logic [sonata_periph_pkg::GpoWidth-1:0] gp_o,
  output logic [sonata_periph_pkg::PwmNum-1:0]   pwm_o,
  output logic                                   timer_irq_o
);

  periph_bus_if gpio_bus ();
  periph_bus_if pwm_bus ();
  periph_bus_if timer_bus ();

  //////////////////////////////////////////////////////////////////////
  // Decoder and devices
  //////////////////////////////////////////////////////////////////////

  periph_decode u_decode (
    .clk_sys_i   (clk_sys_i),
    .rst_n_i     (rst_n_i),
    .bus_req_i   (bus_req_i),
    .bus_we_i    (bus_we_i),
    .bus_addr_i  (bus_addr_i),
    .bus_be_i    (bus_be_i),
    .bus_wdata_i (bus_wdata_i),
    .bus_rvalid_o(bus_rvalid_o),
    .bus_rdata_o (bus_rdata_o),
    .bus_err_o   (bus_err_o),
    .gpio_bus    (gpio_bus),
    .pwm_bus     (pwm_bus),
    .timer_bus   (timer_bus)
  );

  gpio u_gpio (
    .clk_sys_i(clk_sys_i),
    .rst_n_i  (rst_n_i),
    .bus      (gpio_bus),
    .gp_i     (gp_i),
    .gp_o     (gp_o)
  );

  pwm u_pwm (
    .clk_sys_i(clk_sys_i),
    .rst_n_i  (rst_n_i),
    .bus      (pwm_bus),
    .pwm_o    (pwm_o)
  );

  timer u_timer (
    .clk_sys_i  (clk_sys_i),
    .rst_n_i    (rst_n_i),
    .bus        (timer_bus),
    .timer_irq_o(timer_irq_o)
  );

endmodule

// File: rtl/timer.sv
/* Machine timer with a free-running 64-bit mtime, a 64-bit mtimecmp and a
   level timer interrupt raised while mtime >= mtimecmp */
`timescale 1ns/10ps

module timer (
  input  logic         clk_sys_i,
  input  logic         rst_n_i,
  periph_bus_if.device bus,
  output logic         timer_irq_o
);
  import sonata_periph_pkg::*;

  typedef logic [2*BusDataWidth-1:0] dword_t;

  dword_t    mtime_q;
  dword_t    mtimecmp_q;
  logic      irq_q;
  logic      hit;
  logic      wr_en;
  bus_data_t rdata_d;
  logic      rvalid_q;
  logic      err_q;
  bus_data_t rdata_q;

  assign wr_en = bus.req && bus.we;

  // Read mux and offset check
  always_comb begin
    hit     = 1'b1;
    rdata_d = '0;
    case (bus.addr)
      TimerMtimeLo: rdata_d = mtime_q[BusDataWidth-1:0];
      TimerMtimeHi: rdata_d = mtime_q[2*BusDataWidth-1:BusDataWidth];
      TimerCmpLo:   rdata_d = mtimecmp_q[BusDataWidth-1:0];
      TimerCmpHi:   rdata_d = mtimecmp_q[2*BusDataWidth-1:BusDataWidth];
      default:      hit     = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Counter, compare and interrupt
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1; // Compare far away so irq stays low
      irq_q      <= 1'b0;
    end else begin
      mtime_q <= mtime_q + 1'b1;
      irq_q   <= mtime_q >= mtimecmp_q;
      // A written mtime half loads wdata, the other half holds for that cycle
      if (wr_en) begin
        case (bus.addr)
          TimerMtimeLo: mtime_q <= {mtime_q[2*BusDataWidth-1:BusDataWidth], bus.wdata};
          TimerMtimeHi: mtime_q <= {bus.wdata, mtime_q[BusDataWidth-1:0]};
          TimerCmpLo:   mtimecmp_q[BusDataWidth-1:0] <= bus.wdata;
          TimerCmpHi:   mtimecmp_q[2*BusDataWidth-1:BusDataWidth] <= bus.wdata;
          default:      ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus response
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    err_q   <= !hit;
    rdata_q <= bus.we ? '0 : rdata_d; // Zero for writes and bad offsets
  end

  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;
  assign bus.err     = err_q;
  assign timer_irq_o = irq_q;

  // Response exactly one cycle behind each request
  RspLatency_A: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    bus.rvalid == $past(bus.req));

endmodule

// File: test/tb_sonata_periph.sv
/* Testbench for the peripheral subsystem. Drives the register bus on the falling edge
   and checks GPIO, PWM, timer and error responses against a shadow register model */
`timescale 1ns/10ps

module tb_sonata_periph;
  import sonata_periph_pkg::*;

  localparam int unsigned ClkPeriod   = 40;
  localparam int unsigned ResetCycles = 8;
  localparam int unsigned GpioWrites  = 24;
  localparam int unsigned PwmMaxPer   = 32;  // Random periods stay below this
  localparam int unsigned IrqWait     = 400;
  // Rough length of each test in cycles
  localparam int unsigned TestCycles = ResetCycles + 20 + GpioWrites * 3 + 10 +
                                       PwmNum * (2 * PwmMaxPer + 12) + IrqWait + 20 + 30;
  localparam int unsigned WatchdogCycles = TestCycles + 200;

  logic                clk_sys;
  logic                rst_n;
  logic                bus_req;
  logic                bus_we;
  bus_addr_t           bus_addr;
  bus_be_t             bus_be;
  bus_data_t           bus_wdata;
  logic                bus_rvalid;
  logic                bus_err;
  bus_data_t           bus_rdata;
  logic [GpiWidth-1:0] gp_in;
  logic [GpoWidth-1:0] gp_out;
  logic [PwmNum-1:0]   pwm_out;
  logic                timer_irq;

  // Shadow model of the writable registers
  logic [GpoWidth-1:0]   gpo_shadow;
  logic [GpiWidth-1:0]   gpi_shadow;
  logic [PwmCtrSize-1:0] duty_shadow   [PwmNum];
  logic [PwmCtrSize-1:0] period_shadow [PwmNum];
  logic [63:0]           cmp_shadow;
  logic [31:0]           rng_state;

  sonata_periph_top u_dut (
    .clk_sys_i   (clk_sys),
    .rst_n_i     (rst_n),
    .bus_req_i   (bus_req),
    .bus_we_i    (bus_we),
    .bus_addr_i  (bus_addr),
    .bus_be_i    (bus_be),
    .bus_wdata_i (bus_wdata),
    .bus_rvalid_o(bus_rvalid),
    .bus_err_o   (bus_err),
    .bus_rdata_o (bus_rdata),
    .gp_i        (gp_in),
    .gp_o        (gp_out),
    .pwm_o       (pwm_out),
    .timer_irq_o (timer_irq)
  );

  always #(ClkPeriod / 2) clk_sys = ~clk_sys;

  //////////////////////////////////////////////////////////////////////
  // Helpers and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic bus_addr_t dev_addr(logic [DevSelWidth-1:0] sel, reg_addr_t off);
    bus_addr_t a;
    a = '0;
    a[DevSelLsb +: DevSelWidth] = sel;
    a[RegAddrWidth-1:0]         = off;
    return a;
  endfunction

  function automatic logic ref_err(bus_addr_t addr);
    reg_addr_t off;
    off = addr[RegAddrWidth-1:0];
    case (addr[DevSelLsb +: DevSelWidth])
      DevGpio:  return !(off inside {GpioOutOffset, GpioInOffset});
      DevPwm:   return (off / PwmChanStride >= PwmNum) ||
                       !(reg_addr_t'(off % PwmChanStride) inside {PwmDutyOffset, PwmPeriodOffset});
      DevTimer: return !(off inside {TimerMtimeLo, TimerMtimeHi, TimerCmpLo, TimerCmpHi});
      default:  return 1'b1;
    endcase
  endfunction

  // Expected read data of every register except mtime
  function automatic bus_data_t ref_read(bus_addr_t addr);
    reg_addr_t   off;
    int unsigned ch;
    bus_data_t   data;
    off  = addr[RegAddrWidth-1:0];
    ch   = off / PwmChanStride;
    data = '0;
    if (!ref_err(addr)) begin
      case (addr[DevSelLsb +: DevSelWidth])
        DevGpio:  data = (off == GpioOutOffset) ?
                         bus_data_t'(gpo_shadow) : bus_data_t'(gpi_shadow);
        DevPwm:   data = (reg_addr_t'(off % PwmChanStride) == PwmDutyOffset) ?
                         bus_data_t'(duty_shadow[ch]) : bus_data_t'(period_shadow[ch]);
        DevTimer: begin
          if (off == TimerCmpLo) data = cmp_shadow[31:0];
          else if (off == TimerCmpHi) data = cmp_shadow[63:32];
        end
        default:  data = '0;
      endcase
    end
    return data;
  endfunction

  function automatic void apply_write(bus_addr_t addr, bus_be_t be, bus_data_t wdata);
    reg_addr_t   off;
    int unsigned ch;
    off = addr[RegAddrWidth-1:0];
    ch  = off / PwmChanStride;
    if (!ref_err(addr)) begin
      case (addr[DevSelLsb +: DevSelWidth])
        DevGpio: begin
          for (int k = 0; k < GpoWidth; k++) begin
            if (off == GpioOutOffset && be[k/8]) gpo_shadow[k] = wdata[k];
          end
        end
        DevPwm: begin
          if (reg_addr_t'(off % PwmChanStride) == PwmDutyOffset) begin
            duty_shadow[ch] = wdata[PwmCtrSize-1:0];
          end else begin
            period_shadow[ch] = wdata[PwmCtrSize-1:0];
          end
        end
        DevTimer: begin
          if (off == TimerCmpLo) cmp_shadow[31:0] = wdata;
          if (off == TimerCmpHi) cmp_shadow[63:32] = wdata;
        end
        default: ;
      endcase
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks and bus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_error(string line);
    $display("%s", line);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_data(bus_data_t got, bus_data_t exp, string what);
    if (got !== exp) begin
      stop_with_error($sformatf("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp) begin
      stop_with_error($sformatf("mismatch at %0t: %s, got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_count(int unsigned got, int unsigned exp, string what);
    if (got != exp) begin
      stop_with_error($sformatf("mismatch at %0t: %s, got %0d expected %0d",
                                $time, what, got, exp));
    end
  endtask

  // Starts on a falling edge and returns on the falling edge of the response cycle
  task automatic bus_access(input logic we, input bus_addr_t addr, input bus_be_t be,
                            input bus_data_t wdata, output bus_data_t rdata,
                            output logic err);
    bus_req   = 1'b1;
    bus_we    = we;
    bus_addr  = addr;
    bus_be    = be;
    bus_wdata = wdata;
    @(posedge clk_sys);
    @(negedge clk_sys);
    bus_req = 1'b0;
    if (!bus_rvalid) begin
      stop_with_error($sformatf("no bus response one cycle after the request to %h", addr));
    end
    rdata = bus_rdata;
    err   = bus_err;
  endtask

  task automatic bus_write(bus_addr_t addr, bus_be_t be, bus_data_t wdata);
    bus_data_t rdata;
    logic      err;
    bus_access(1'b1, addr, be, wdata, rdata, err);
    check_flag(err, ref_err(addr), $sformatf("write error flag at %h", addr));
    check_data(rdata, '0, $sformatf("write response data at %h", addr));
    apply_write(addr, be, wdata);
  endtask

  task automatic read_check(bus_addr_t addr, string what);
    bus_data_t rdata;
    logic      err;
    bus_access(1'b0, addr, '1, '0, rdata, err);
    check_flag(err, ref_err(addr), {what, " error flag"});
    check_data(rdata, ref_read(addr), what);
  endtask

  task automatic read_value(bus_addr_t addr, output bus_data_t rdata);
    logic err;
    bus_access(1'b0, addr, '1, '0, rdata, err);
    check_flag(err, 1'b0, $sformatf("read error flag at %h", addr));
  endtask

  task automatic idle(int unsigned cycles);
    repeat (cycles) begin
      @(negedge clk_sys);
      check_flag(bus_rvalid, 1'b0, "rvalid without a request");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    bus_data_t   r;
    bus_data_t   t1;
    bus_data_t   t2;
    reg_addr_t   base;
    int unsigned per;
    int unsigned duty;
    int unsigned high;
    logic        seen;
    clk_sys   = 1'b0;
    rst_n     = 1'b0;
    bus_req   = 1'b0;
    bus_we    = 1'b0;
    bus_addr  = '0;
    bus_be    = '0;
    bus_wdata = '0;
    gp_in     = '0;
    rng_state = 32'd37;
    gpo_shadow = '0;
    gpi_shadow = '0;
    cmp_shadow = '1;
    for (int ch = 0; ch < PwmNum; ch++) begin
      duty_shadow[ch]   = '0;
      period_shadow[ch] = '0;
    end
    repeat (ResetCycles) @(negedge clk_sys);
    rst_n = 1'b1;
    @(negedge clk_sys);

    // Reset state
    check_flag(bus_rvalid, 1'b0, "rvalid after reset");
    check_flag(bus_err, 1'b0, "bus error flag after reset");
    check_flag(timer_irq, 1'b0, "timer irq after reset");
    check_data(bus_data_t'(gp_out), '0, "gp_o after reset");
    check_data(bus_data_t'(pwm_out), '0, "pwm_o after reset");
    read_check(dev_addr(DevGpio, GpioOutOffset), "gpio out after reset");
    read_check(dev_addr(DevGpio, GpioInOffset), "gpio in after reset");
    for (int ch = 0; ch < PwmNum; ch++) begin
      base = reg_addr_t'(ch * PwmChanStride);
      read_check(dev_addr(DevPwm, base + PwmDutyOffset), "pwm duty after reset");
      read_check(dev_addr(DevPwm, base + PwmPeriodOffset), "pwm period after reset");
    end
    read_check(dev_addr(DevTimer, TimerCmpLo), "mtimecmp low after reset");
    read_check(dev_addr(DevTimer, TimerCmpHi), "mtimecmp high after reset");
    idle(2);

    // GPIO output with random byte enables, then a steady input
    for (int n = 0; n < GpioWrites; n++) begin
      r = next_random();
      bus_write(dev_addr(DevGpio, GpioOutOffset), r[3:0], next_random());
      check_data(bus_data_t'(gp_out), bus_data_t'(gpo_shadow), "gp_o after write");
      read_check(dev_addr(DevGpio, GpioOutOffset), "gpio out readback");
    end
    r = next_random();
    gp_in      = r[GpiWidth-1:0];
    gpi_shadow = gp_in;
    idle(3);
    read_check(dev_addr(DevGpio, GpioInOffset), "gpio in after sync");

    // PWM high count over one period per channel
    for (int ch = 0; ch < PwmNum; ch++) begin
      base = reg_addr_t'(ch * PwmChanStride);
      per  = next_random() % PwmMaxPer;
      duty = next_random() % (per + 2);
      bus_write(dev_addr(DevPwm, base + PwmPeriodOffset), '1, bus_data_t'(per));
      bus_write(dev_addr(DevPwm, base + PwmDutyOffset), '1, bus_data_t'(duty));
      read_check(dev_addr(DevPwm, base + PwmPeriodOffset), "pwm period readback");
      read_check(dev_addr(DevPwm, base + PwmDutyOffset), "pwm duty readback");
      idle(2);
      high = 0;
      for (int c = 0; c <= int'(per); c++) begin
        @(negedge clk_sys);
        if (pwm_out[ch]) high++;
      end
      check_count(high, duty, $sformatf("pwm channel %0d high cycles", ch));
    end

    // Timer count and compare interrupt
    read_value(dev_addr(DevTimer, TimerMtimeLo), t1);
    read_value(dev_addr(DevTimer, TimerMtimeLo), t2);
    check_flag(t2 > t1, 1'b1, "mtime strictly increasing");
    read_value(dev_addr(DevTimer, TimerMtimeLo), t1);
    bus_write(dev_addr(DevTimer, TimerCmpLo), '1, t1 + 32'd200);
    bus_write(dev_addr(DevTimer, TimerCmpHi), '1, '0);
    read_check(dev_addr(DevTimer, TimerCmpLo), "mtimecmp low readback");
    read_check(dev_addr(DevTimer, TimerCmpHi), "mtimecmp high readback");
    // The registered irq now reflects the new compare value
    check_flag(timer_irq, 1'b0, "timer irq before mtime reaches compare");
    seen = 1'b0;
    for (int c = 0; c < IrqWait && !seen; c++) begin
      @(negedge clk_sys);
      seen = timer_irq;
    end
    if (!seen) begin
      stop_with_error("timer interrupt never went high after the compare value was set");
    end
    read_value(dev_addr(DevTimer, TimerMtimeLo), t2);
    check_flag(t2 >= cmp_shadow[31:0], 1'b1, "mtime reached compare at interrupt");

    // Unmapped devices and unknown offsets
    read_check(dev_addr(4'h3, GpioOutOffset), "read of unmapped device");
    bus_write(dev_addr(4'hF, GpioOutOffset), '1, next_random());
    bus_write(dev_addr(DevGpio, 8'h08), '1, next_random());
    bus_write(dev_addr(DevPwm, 8'h20), '1, next_random());
    bus_write(dev_addr(DevPwm, 8'h02), '1, next_random());
    bus_write(dev_addr(DevTimer, 8'h10), '1, next_random());
    check_data(bus_data_t'(gp_out), bus_data_t'(gpo_shadow), "gp_o after bad writes");
    read_check(dev_addr(DevGpio, GpioOutOffset), "gpio out after bad writes");
    read_check(dev_addr(DevGpio, 8'h08), "gpio unknown offset");
    read_check(dev_addr(DevPwm, PwmDutyOffset), "pwm duty after bad writes");
    read_check(dev_addr(DevPwm, PwmPeriodOffset), "pwm period after bad writes");
    read_check(dev_addr(DevPwm, 8'h20), "pwm channel out of range");
    read_check(dev_addr(DevTimer, TimerCmpLo), "mtimecmp low after bad writes");
    read_check(dev_addr(DevTimer, 8'h10), "timer unknown offset");
    idle(2);

    $display("Simulation finished: PASS");
    $finish;
  end

  // Watchdog
  initial begin
    #(WatchdogCycles * ClkPeriod);
    stop_with_error("timeout: the test did not finish within the expected number of cycles");
  end

endmodule
